/* verilog/gambitCfg.svh */
`ifndef GAMBIT_CFG_SVH
`define GAMBIT_CFG_SVH

// ====================
// decode front end sizes
// ====================

// fetched instruction width
`define INSTR_W 52
// sign-extended constant width
`define CONST_W 52

// fetch buffer entries, also the credits the fetch unit starts with
`define FETCH_DEPTH 4

// issue queue entries available to dispatch after reset
`define IQ_CREDITS 4

// sequence tag width, wraps at 16
`define SEQ_W 4

`endif

/* verilog/gambitPkg.sv */
`default_nettype none
`include "gambitCfg.svh"

package gambitPkg;

	// ====================
	// opcodes
	// ====================

	// decoded subset, grouped by unit
	typedef enum logic [6:0]
	{
		// alu group
		ADD_3R   = 7'h10, ADD_RI22  = 7'h11, ADD_RI35  = 7'h12,
		SUB_3R   = 7'h13, SUB_RI22  = 7'h14, SUB_RI35  = 7'h15,
		AND_3R   = 7'h16, AND_RI22  = 7'h17, AND_RI35  = 7'h18,
		OR_3R    = 7'h19, OR_RI22   = 7'h1A, OR_RI35   = 7'h1B,
		CMP_3R   = 7'h1C, CMP_RI22  = 7'h1D, CMP_RI35  = 7'h1E,
		CMPU_3R  = 7'h1F, CMPU_RI22 = 7'h20, CMPU_RI35 = 7'h21,
		// runs on alu0 only
		CSR      = 7'h0F,
		// memory group
		LD_D8    = 7'h40, LD_D22    = 7'h41, LD_D35    = 7'h42,
		LDB_D8   = 7'h43, LDB_D22   = 7'h44, LDB_D35   = 7'h45,
		ST_D8    = 7'h50, ST_D22    = 7'h51, ST_D35    = 7'h52,
		STB_D8   = 7'h53, STB_D22   = 7'h54, STB_D35   = 7'h55,
		// flow control
		JAL      = 7'h60,
		BRANCH0  = 7'h61,
		BRANCH1  = 7'h62,
		STPGRP   = 7'h6F
	} opcodeE;

	// memory access size
	typedef enum logic [2:0]
	{
		BYTE = 3'd0,
		WORD = 3'd1
	} memSizeE;

	// dispatch control state
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		ISSUE = 2'd1,
		STALL = 2'd2
	} dispStateE;

	// ====================
	// bundles
	// ====================

	// imm[0] sits at instruction bit 17
	// branch displacement is imm[11:0]
	typedef struct packed
	{
		logic [34:0] imm;
		// set for the non-indexed d8 form
		logic        one;
		// register fields, not decoded here
		logic [8:0]  regs;
		opcodeE      opcode;
	} instrT;

	// one fetch buffer entry
	typedef struct packed
	{
		instrT instr;
		logic  predictTaken;
	} fetchEntryT;

	// classification of one instruction
	typedef struct packed
	{
		logic                isAlu;
		logic                isAlu0;
		logic                isCmp;
		logic                isFlowCtrl;
		logic                isLoad;
		logic                isStore;
		logic                isMem;
		memSizeE             memSize;
		logic                isMemNdx;
		logic                isJal;
		logic                isBranch;
		logic                isRfw;
		logic                predictTaken;
		logic [`CONST_W-1:0] constVal;
	} decodeBusT;

	// what leaves toward the issue queue
	typedef struct packed
	{
		decodeBusT        bus;
		logic [`SEQ_W-1:0] seq;
	} dispatchT;

endpackage

`default_nettype wire

/* verilog/fetchBuffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gambitCfg.svh"

module fetchBuffer
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  fetchValid,
	input  wire gambitPkg::fetchEntryT fetchEntry,
	input  wire logic                  pop,
	output gambitPkg::fetchEntryT      head,
	output logic                       notEmpty,
	output logic                       fetchCredit
);

	localparam int PTR_W = $clog2(`FETCH_DEPTH);
	localparam int CNT_W = $clog2(`FETCH_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`FETCH_DEPTH - 1);

	// entry storage
	gambitPkg::fetchEntryT mem [`FETCH_DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic             full;

	// circular pointer step, works for any depth
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		nextPtr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	// ====================
	// storage
	// ====================

	// upstream only writes while it holds a credit
	always_ff @(posedge clk)
	begin
		if (fetchValid)
			mem[wrPtr] <= fetchEntry;
	end

	assign head     = mem[rdPtr];
	assign notEmpty = (count != '0);
	assign full     = (count == CNT_W'(`FETCH_DEPTH));

	// ====================
	// pointers and credits
	// ====================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			count       <= '0;
			fetchCredit <= 1'b0;
		end
		else
		begin
			if (fetchValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			// simultaneous write and pop leave the count alone
			case ({fetchValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// freed slot goes back upstream one cycle later
			fetchCredit <= pop;
		end
	end

	// fetch unit wrote without a credit
	aNoWriteFull: assert property (@(posedge clk) disable iff (rst) !(fetchValid && full))
		else $error("fetch buffer written while full");

	// dispatch popped an empty buffer
	aNoPopEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
		else $error("fetch buffer popped while empty");

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gambitCfg.svh"

module instrDecoder
(
	input  wire gambitPkg::instrT instr,
	input  wire logic             predictTaken,
	output gambitPkg::decodeBusT  decoded
);

	// ====================
	// classification
	// ====================

	// every alu group opcode, csr included
	function automatic logic isAluOp(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::ADD_3R, gambitPkg::ADD_RI22, gambitPkg::ADD_RI35,
			gambitPkg::SUB_3R, gambitPkg::SUB_RI22, gambitPkg::SUB_RI35,
			gambitPkg::AND_3R, gambitPkg::AND_RI22, gambitPkg::AND_RI35,
			gambitPkg::OR_3R, gambitPkg::OR_RI22, gambitPkg::OR_RI35,
			gambitPkg::CMP_3R, gambitPkg::CMP_RI22, gambitPkg::CMP_RI35,
			gambitPkg::CMPU_3R, gambitPkg::CMPU_RI22, gambitPkg::CMPU_RI35,
			gambitPkg::CSR:
				isAluOp = 1'b1;
			default:
				isAluOp = 1'b0;
		endcase
	endfunction

	// signed and unsigned compares
	function automatic logic isCmpOp(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::CMP_3R, gambitPkg::CMP_RI22, gambitPkg::CMP_RI35,
			gambitPkg::CMPU_3R, gambitPkg::CMPU_RI22, gambitPkg::CMPU_RI35:
				isCmpOp = 1'b1;
			default:
				isCmpOp = 1'b0;
		endcase
	endfunction

	function automatic logic isLoadOp(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::LD_D8, gambitPkg::LD_D22, gambitPkg::LD_D35,
			gambitPkg::LDB_D8, gambitPkg::LDB_D22, gambitPkg::LDB_D35:
				isLoadOp = 1'b1;
			default:
				isLoadOp = 1'b0;
		endcase
	endfunction

	function automatic logic isStoreOp(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::ST_D8, gambitPkg::ST_D22, gambitPkg::ST_D35,
			gambitPkg::STB_D8, gambitPkg::STB_D22, gambitPkg::STB_D35:
				isStoreOp = 1'b1;
			default:
				isStoreOp = 1'b0;
		endcase
	endfunction

	// byte forms, everything else moves a word
	function automatic gambitPkg::memSizeE memSizeOf(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::LDB_D8, gambitPkg::LDB_D22, gambitPkg::LDB_D35,
			gambitPkg::STB_D8, gambitPkg::STB_D22, gambitPkg::STB_D35:
				memSizeOf = gambitPkg::BYTE;
			default:
				memSizeOf = gambitPkg::WORD;
		endcase
	endfunction

	// d8 memory forms are indexed unless the one bit is set
	function automatic logic isMemNdxOp(input gambitPkg::instrT isn);
		case (isn.opcode)
			gambitPkg::LD_D8, gambitPkg::LDB_D8, gambitPkg::ST_D8, gambitPkg::STB_D8:
				isMemNdxOp = ~isn.one;
			default:
				isMemNdxOp = 1'b0;
		endcase
	endfunction

	function automatic logic isFlowCtrlOp(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::JAL, gambitPkg::BRANCH0, gambitPkg::BRANCH1, gambitPkg::STPGRP:
				isFlowCtrlOp = 1'b1;
			default:
				isFlowCtrlOp = 1'b0;
		endcase
	endfunction

	// predictable branches only
	function automatic logic isBranchOp(input gambitPkg::opcodeE op);
		isBranchOp = (op == gambitPkg::BRANCH0) || (op == gambitPkg::BRANCH1);
	endfunction

	// 8 bit immediate or displacement field
	function automatic logic hasConst8(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::ADD_3R, gambitPkg::SUB_3R, gambitPkg::AND_3R,
			gambitPkg::OR_3R, gambitPkg::CMP_3R, gambitPkg::CMPU_3R,
			gambitPkg::LD_D8, gambitPkg::LDB_D8, gambitPkg::ST_D8, gambitPkg::STB_D8:
				hasConst8 = 1'b1;
			default:
				hasConst8 = 1'b0;
		endcase
	endfunction

	// 22 bit field
	function automatic logic hasConst22(input gambitPkg::opcodeE op);
		case (op)
			gambitPkg::ADD_RI22, gambitPkg::SUB_RI22, gambitPkg::AND_RI22,
			gambitPkg::OR_RI22, gambitPkg::CMP_RI22, gambitPkg::CMPU_RI22,
			gambitPkg::LD_D22, gambitPkg::LDB_D22, gambitPkg::ST_D22, gambitPkg::STB_D22:
				hasConst22 = 1'b1;
			default:
				hasConst22 = 1'b0;
		endcase
	endfunction

	// ====================
	// bundle
	// ====================

	always_comb
	begin
		decoded.isAlu        = isAluOp(instr.opcode);
		decoded.isAlu0       = (instr.opcode == gambitPkg::CSR);
		decoded.isCmp        = isCmpOp(instr.opcode);
		decoded.isFlowCtrl   = isFlowCtrlOp(instr.opcode);
		decoded.isLoad       = isLoadOp(instr.opcode);
		decoded.isStore      = isStoreOp(instr.opcode);
		// loads and stores are the whole memory group
		decoded.isMem        = isLoadOp(instr.opcode) | isStoreOp(instr.opcode);
		decoded.memSize      = memSizeOf(instr.opcode);
		decoded.isMemNdx     = isMemNdxOp(instr);
		decoded.isJal        = (instr.opcode == gambitPkg::JAL);
		decoded.isBranch     = isBranchOp(instr.opcode);
		// stores, branches and stpgrp write no register
		decoded.isRfw        = ~(isStoreOp(instr.opcode) | isBranchOp(instr.opcode)
			| (instr.opcode == gambitPkg::STPGRP));
		decoded.predictTaken = predictTaken;
		// branch displacement wins, then the narrowest immediate
		if (isBranchOp(instr.opcode))
			decoded.constVal = {{(`CONST_W - 12){instr.imm[11]}}, instr.imm[11:0]};
		else if (hasConst8(instr.opcode))
			decoded.constVal = {{(`CONST_W - 8){instr.imm[7]}}, instr.imm[7:0]};
		else if (hasConst22(instr.opcode))
			decoded.constVal = {{(`CONST_W - 22){instr.imm[21]}}, instr.imm[21:0]};
		else
			decoded.constVal = {{(`CONST_W - 35){instr.imm[34]}}, instr.imm[34:0]};
	end

endmodule

`default_nettype wire

/* verilog/dispatchCtrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gambitCfg.svh"

module dispatchCtrl
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 notEmpty,
	input  wire gambitPkg::decodeBusT decoded,
	input  wire logic                 iqCredit,
	output logic                      pop,
	output logic                      dispValid,
	output gambitPkg::dispatchT       dispOut
);

	localparam int CRED_W = $clog2(`IQ_CREDITS + 1);

	// free issue queue slots
	logic [CRED_W-1:0] creditCnt;
	gambitPkg::dispStateE dispState;
	// tag for the next dispatch
	logic [`SEQ_W-1:0] seqTag;

	// ====================
	// state and pop
	// ====================

	// nothing waiting, dispatching, or waiting on credits
	always_comb
	begin
		if (!notEmpty)
			dispState = gambitPkg::IDLE;
		else if (creditCnt != '0)
			dispState = gambitPkg::ISSUE;
		else
			dispState = gambitPkg::STALL;
	end

	assign pop = (dispState == gambitPkg::ISSUE);

	// ====================
	// counters
	// ====================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			creditCnt <= CRED_W'(`IQ_CREDITS);
			seqTag    <= '0;
			dispValid <= 1'b0;
		end
		else
		begin
			// a return and a dispatch in one cycle cancel
			case ({pop, iqCredit})
				2'b10:   creditCnt <= creditCnt - 1'b1;
				2'b01:   creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
			// tag wraps naturally at the field width
			if (pop)
				seqTag <= seqTag + 1'b1;
			dispValid <= pop;
		end
	end

	// output register, payload only
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			dispOut.bus <= decoded;
			dispOut.seq <= seqTag;
		end
	end

	// issue queue returned a credit it never received
	aCreditLimit: assert property (@(posedge clk) disable iff (rst)
		(iqCredit && !pop) |-> (creditCnt < CRED_W'(`IQ_CREDITS)))
		else $error("issue credit count above limit");

endmodule

`default_nettype wire

/* verilog/decodeFrontEnd.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeFrontEnd
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  fetchValid,
	input  wire gambitPkg::fetchEntryT fetchEntry,
	input  wire logic                  iqCredit,
	output logic                       fetchCredit,
	output logic                       dispValid,
	output gambitPkg::dispatchT        dispOut
);

	// oldest buffered entry
	gambitPkg::fetchEntryT head;
	logic                  notEmpty;
	logic                  pop;
	// classification of the head entry
	gambitPkg::decodeBusT  decoded;

	// ====================
	// fetch side
	// ====================

	fetchBuffer i_fetchBuffer
	(
		.clk         (clk),
		.rst         (rst),
		.fetchValid  (fetchValid),
		.fetchEntry  (fetchEntry),
		.pop         (pop),
		.head        (head),
		.notEmpty    (notEmpty),
		.fetchCredit (fetchCredit)
	);

	// decode is combinational on the head
	instrDecoder i_instrDecoder
	(
		.instr        (head.instr),
		.predictTaken (head.predictTaken),
		.decoded      (decoded)
	);

	// ====================
	// dispatch side
	// ====================

	dispatchCtrl i_dispatchCtrl
	(
		.clk       (clk),
		.rst       (rst),
		.notEmpty  (notEmpty),
		.decoded   (decoded),
		.iqCredit  (iqCredit),
		.pop       (pop),
		.dispValid (dispValid),
		.dispOut   (dispOut)
	);

endmodule

`default_nettype wire

/* verification/decodeChecker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gambitCfg.svh"

module decodeChecker
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  fetchValid,
	input  wire gambitPkg::fetchEntryT fetchEntry,
	input  wire logic                  iqCredit,
	input  wire logic                  dispValid,
	input  wire gambitPkg::dispatchT   dispOut,
	input  wire logic                  testDone,
	input  var int                     testNum,
	input  var int                     fetchCreds,
	output int                         testsPassed,
	output int                         testsFailed
);

	// entries written into the buffer, oldest first
	gambitPkg::fetchEntryT expQ [$];
	gambitPkg::fetchEntryT expEntry;
	gambitPkg::decodeBusT  want;
	gambitPkg::decodeBusT  got;
	logic [`SEQ_W-1:0]     expSeq;
	// dispatches not yet answered by an iqCredit
	int outstanding;
	int testErrs;
	int creditErrs;

	// ====================
	// reference decode
	// ====================

	// classification worked out from the mnemonic, family before the underscore
	function automatic gambitPkg::decodeBusT refDecode(input gambitPkg::fetchEntryT e);
		gambitPkg::decodeBusT r;
		string nm;
		string fam;
		string form;
		int i;
		int width;
		logic [`CONST_W-1:0] raw;
		nm = e.instr.opcode.name();
		fam = nm;
		form = "";
		for (i = 0; i < nm.len(); i++)
		begin
			// underscore splits family and form
			if (nm[i] == 8'h5F)
			begin
				fam = nm.substr(0, i - 1);
				form = nm.substr(i + 1, nm.len() - 1);
			end
		end
		r = '0;
		r.isLoad = (fam == "LD") || (fam == "LDB");
		r.isStore = (fam == "ST") || (fam == "STB");
		r.isMem = r.isLoad || r.isStore;
		r.memSize = (fam == "LDB" || fam == "STB") ? gambitPkg::BYTE : gambitPkg::WORD;
		r.isCmp = (fam == "CMP") || (fam == "CMPU");
		r.isAlu0 = (fam == "CSR");
		r.isAlu = r.isCmp || r.isAlu0 || fam == "ADD" || fam == "SUB" || fam == "AND"
			|| fam == "OR";
		r.isJal = (fam == "JAL");
		r.isBranch = (fam == "BRANCH0") || (fam == "BRANCH1");
		r.isFlowCtrl = r.isJal || r.isBranch || (fam == "STPGRP");
		r.isRfw = !(r.isStore || r.isBranch || fam == "STPGRP");
		// indexed unless the one bit marks the plain d8 form
		r.isMemNdx = (form == "D8") && !e.instr.one;
		r.predictTaken = e.predictTaken;
		if (r.isBranch)
			width = 12;
		else if (form == "3R" || form == "D8")
			width = 8;
		else if (form == "RI22" || form == "D22")
			width = 22;
		else
			width = 35;
		// shift the field to the top, then back down arithmetically
		raw = `CONST_W'(e.instr.imm);
		r.constVal = $signed(raw << (`CONST_W - width)) >>> (`CONST_W - width);
		return r;
	endfunction

	task automatic checkField(input string name, input logic [63:0] gotV,
		input logic [63:0] wantV);
		if (gotV !== wantV)
		begin
			$display("mismatch %s seq %h: got %h expected %h", name, dispOut.seq, gotV, wantV);
			testErrs++;
		end
	endtask

	// closes one test, leftovers and credit totals first
	task automatic reportTest();
		if (expQ.size() != 0)
		begin
			$display("%0d instructions were written but never dispatched", expQ.size());
			testErrs++;
			expQ.delete();
		end
		if (testNum == 5)
		begin
			testErrs += creditErrs;
			if (fetchCreds != `FETCH_DEPTH)
			begin
				$display("fetch credits ended at %0d instead of %0d", fetchCreds, `FETCH_DEPTH);
				testErrs++;
			end
		end
		if (testErrs == 0)
		begin
			$display("test %0d passed", testNum);
			testsPassed++;
		end
		else
		begin
			$display("test %0d failed with %0d errors", testNum, testErrs);
			testsFailed++;
		end
		testErrs = 0;
	endtask

	// ====================
	// monitor
	// ====================

	// inputs seen here are the ones the DUT took at the last rising edge
	always @(negedge clk)
	begin
		if (rst)
		begin
			expQ.delete();
			expSeq = '0;
			outstanding = 0;
			testErrs = 0;
			creditErrs = 0;
			testsPassed = 0;
			testsFailed = 0;
		end
		else
		begin
			if (fetchValid)
				expQ.push_back(fetchEntry);
			if (iqCredit)
				outstanding--;
			if (dispValid)
			begin
				outstanding++;
				if (outstanding > `IQ_CREDITS)
				begin
					$display("%0d dispatches outstanding, more than the issue queue holds",
						outstanding);
					creditErrs++;
				end
				if (expQ.size() == 0)
				begin
					$display("dispatch with seq %h but no instruction was waiting", dispOut.seq);
					testErrs++;
				end
				else
				begin
					expEntry = expQ.pop_front();
					want = refDecode(expEntry);
					got = dispOut.bus;
					checkField("seq", 64'(dispOut.seq), 64'(expSeq));
					checkField("isAlu", 64'(got.isAlu), 64'(want.isAlu));
					checkField("isAlu0", 64'(got.isAlu0), 64'(want.isAlu0));
					checkField("isCmp", 64'(got.isCmp), 64'(want.isCmp));
					checkField("isFlowCtrl", 64'(got.isFlowCtrl), 64'(want.isFlowCtrl));
					checkField("isLoad", 64'(got.isLoad), 64'(want.isLoad));
					checkField("isStore", 64'(got.isStore), 64'(want.isStore));
					checkField("isMem", 64'(got.isMem), 64'(want.isMem));
					checkField("memSize", 64'(got.memSize), 64'(want.memSize));
					checkField("isMemNdx", 64'(got.isMemNdx), 64'(want.isMemNdx));
					checkField("isJal", 64'(got.isJal), 64'(want.isJal));
					checkField("isBranch", 64'(got.isBranch), 64'(want.isBranch));
					checkField("isRfw", 64'(got.isRfw), 64'(want.isRfw));
					checkField("predictTaken", 64'(got.predictTaken), 64'(want.predictTaken));
					checkField("constVal", 64'(got.constVal), 64'(want.constVal));
				end
				// tag wraps with its width
				expSeq = expSeq + 1'b1;
			end
			if (testDone)
				reportTest();
		end
	end

endmodule

`default_nettype wire

/* verification/tbDecodeFrontEnd.sv */
`timescale 1ns/1ps
`default_nettype none
`include "gambitCfg.svh"

module tbDecodeFrontEnd;

	// instructions per test
	localparam int N_ALU = 19 * 2;
	localparam int N_MEM = 12 * 4;
	localparam int N_FLOW = 4 * 4;
	localparam int N_RAND = 200;
	localparam int N_TOTAL = N_ALU + N_MEM + N_FLOW + N_RAND;
	// forty cycles per instruction plus margin for reset and drains
	localparam int CYCLE_LIMIT = 40 * N_TOTAL + 200;

	logic                  clk = 1'b0;
	logic                  rst = 1'b1;
	logic                  fetchValid = 1'b0;
	gambitPkg::fetchEntryT fetchEntry = '0;
	logic                  iqCredit = 1'b0;
	logic                  fetchCredit;
	logic                  dispValid;
	gambitPkg::dispatchT   dispOut;

	// stimulus, generated before reset ends
	gambitPkg::fetchEntryT stim [N_TOTAL];
	gambitPkg::opcodeE     opList [35];
	integer seed = 32'hae0b7503;
	int nStim = 0;
	int sendIdx = 0;
	int sendLimit = 0;
	int dispCount = 0;
	int fetchCreds = `FETCH_DEPTH;
	int cycles = 0;
	// issue queue model, cycle at which each credit goes back
	int retQ [$];
	int lastDue = 0;
	int due;
	logic testDone = 1'b0;
	int testNum = 0;
	int testsPassed;
	int testsFailed;

	always #10 clk = ~clk;

	decodeFrontEnd i_dut
	(
		.clk         (clk),
		.rst         (rst),
		.fetchValid  (fetchValid),
		.fetchEntry  (fetchEntry),
		.iqCredit    (iqCredit),
		.fetchCredit (fetchCredit),
		.dispValid   (dispValid),
		.dispOut     (dispOut)
	);

	decodeChecker i_checker
	(
		.clk         (clk),
		.rst         (rst),
		.fetchValid  (fetchValid),
		.fetchEntry  (fetchEntry),
		.iqCredit    (iqCredit),
		.dispValid   (dispValid),
		.dispOut     (dispOut),
		.testDone    (testDone),
		.testNum     (testNum),
		.fetchCreds  (fetchCreds),
		.testsPassed (testsPassed),
		.testsFailed (testsFailed)
	);

	// random fields and predict bit, opcode forced
	task automatic addStim(input gambitPkg::opcodeE op);
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		stim[nStim] = r[52:0];
		stim[nStim].instr.opcode = op;
		nStim++;
	endtask

	// opens the sender up to lastIdx, waits for the drain, then closes the test
	task automatic runTest(input int num, input int lastIdx);
		sendLimit <= lastIdx;
		do
			@(posedge clk);
		while (dispCount < lastIdx || retQ.size() != 0);
		// last credit pulses land in the next cycles
		repeat (3) @(posedge clk);
		@(negedge clk);
		testNum <= num;
		testDone <= 1'b1;
		@(negedge clk);
		testDone <= 1'b0;
	endtask

	// ====================
	// fetch unit and issue queue
	// ====================

	always @(negedge clk)
	begin
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, %0d of %0d sent instructions never dispatched",
				cycles, sendIdx - dispCount, sendIdx);
			$display("Regression failed");
			$finish;
		end
		else if (rst)
		begin
			fetchValid <= 1'b0;
			iqCredit <= 1'b0;
			fetchCreds = `FETCH_DEPTH;
		end
		else
		begin
			cycles++;
			if (fetchCredit)
				fetchCreds++;
			// each dispatch returns one credit 0 to 7 cycles later, in order
			if (dispValid)
			begin
				dispCount++;
				due = cycles + int'($unsigned($random(seed)) % 8);
				if (due < lastDue)
					due = lastDue;
				retQ.push_back(due);
				lastDue = due;
			end
			if (retQ.size() != 0 && retQ[0] <= cycles)
			begin
				iqCredit <= 1'b1;
				void'(retQ.pop_front());
			end
			else
				iqCredit <= 1'b0;
			// send only while holding a fetch credit
			if (sendIdx < sendLimit && fetchCreds > 0)
			begin
				fetchValid <= 1'b1;
				fetchEntry <= stim[sendIdx];
				sendIdx++;
				fetchCreds--;
			end
			else
				fetchValid <= 1'b0;
		end
	end

	// ====================
	// test sequence
	// ====================

	initial
	begin
		gambitPkg::opcodeE op;
		int i;
		// declaration order: alu group and csr, memory group, flow control
		op = op.first();
		for (i = 0; i < 35; i++)
		begin
			opList[i] = op;
			op = op.next();
		end
		for (i = 0; i < 19; i++)
			repeat (2) addStim(opList[i]);
		for (i = 19; i < 31; i++)
			repeat (4) addStim(opList[i]);
		for (i = 31; i < 35; i++)
			repeat (4) addStim(opList[i]);
		for (i = 0; i < N_RAND; i++)
			addStim(opList[$unsigned($random(seed)) % 35]);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;
		runTest(1, N_ALU);
		runTest(2, N_ALU + N_MEM);
		runTest(3, N_ALU + N_MEM + N_FLOW);
		runTest(4, N_TOTAL);
		// credit totals, with the pipeline idle
		runTest(5, N_TOTAL);
		@(posedge clk);
		$display("tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/gambitPkg.sv
verilog/fetchBuffer.sv
verilog/instrDecoder.sv
verilog/dispatchCtrl.sv
verilog/decodeFrontEnd.sv
verification/decodeChecker.sv
verification/tbDecodeFrontEnd.sv

/* run.sh */
#!/bin/sh
# compile the decode front end with its testbench, then run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbDecodeFrontEnd \
	-f build.f -o simv || exit 1
# output goes to the terminal, the search decides the exit status
./obj_dir/simv | tee /dev/stderr | grep "Regression passed" > /dev/null && exit 0 || exit 1
